//--- verilog/topic_pkg.sv
`default_nettype none

package topic_pkg;

	typedef logic [15:0] key_t;      // topic key.
	typedef logic [15:0] etime_t;    // expiry time.
	typedef logic [31:0] apb_data_t; // apb data word, also used for the word address.

	typedef enum logic [2:0] {
		IDLE,
		PROBE,
		KEY0,
		KEY1,
		EXPIRY
	} lookup_state_t;

	////////////////////////////////////////
	// hash functions
	////////////////////////////////////////

	// xor of the four nibbles, cut down to the table depth.
	function automatic key_t topic_hash0(key_t key, int unsigned depth_nbits);
		logic [3:0] fold;
		fold = key[15:12] ^ key[11:8] ^ key[7:4] ^ key[3:0];
		return key_t'(fold) & ((key_t'(1) << depth_nbits) - key_t'(1));
	endfunction

	function automatic key_t topic_hash1(key_t key, int unsigned depth_nbits);
		key_t rot;
		rot = {key[10:0], key[15:11]}; // rotate left by 5.
		return topic_hash0(rot, depth_nbits);
	endfunction

	////////////////////////////////////////
	// apb address regions
	////////////////////////////////////////

	function automatic logic apb_is_key_region(apb_data_t paddr, int unsigned depth_nbits);
		return paddr[depth_nbits+1];
	endfunction

	function automatic logic apb_table_sel(apb_data_t paddr, int unsigned depth_nbits);
		return paddr[depth_nbits]; // 0 picks table 0, 1 picks table 1.
	endfunction

endpackage

`default_nettype wire

//--- verilog/ram_1r1w.sv
`timescale 1ns/1ps
`default_nettype none

module ram_1r1w #(
	parameter int width = 16,
	parameter int depth_nbits = 4
) (
	input wire clk,

	input wire wr,
	input wire [depth_nbits-1:0] waddr,
	input wire [width-1:0] din,

	input wire [depth_nbits-1:0] raddr,
	output logic [width-1:0] dout
);

	logic [width-1:0] mem [0:(1<<depth_nbits)-1];

	// registered read, a same-address write shows up on the next read only.
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
		dout <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- verilog/pio_rw_wmem.sv
`timescale 1ns/1ps
`default_nettype none

module pio_rw_wmem #(
	parameter int width = 5,
	parameter int depth_nbits = 4
) (
	input wire clk,
	input wire reset,

	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire topic_pkg::apb_data_t paddr,
	input wire topic_pkg::apb_data_t pwdata,
	output logic pready,
	output topic_pkg::apb_data_t prdata,

	input wire app_mem_rd,
	input wire [depth_nbits-1:0] app_mem_raddr,
	output logic app_mem_ack,
	output logic [width-1:0] app_mem_rdata,

	input wire init_wr,
	input wire [depth_nbits-1:0] init_addr
);

	import topic_pkg::*;

	logic access;
	logic mem_free;
	logic apb_wr;
	logic apb_rd;
	logic rd_pending;

	logic [depth_nbits-1:0] apb_index;
	logic ram_wr;
	logic [depth_nbits-1:0] ram_waddr;
	logic [width-1:0] ram_din;
	logic [depth_nbits-1:0] ram_raddr;
	logic [width-1:0] ram_dout;

	assign apb_index = paddr[depth_nbits-1:0];
	assign access = psel & penable;
	assign mem_free = ~app_mem_rd & ~init_wr; // application reads and clear go first.

	assign apb_wr = access & pwrite & mem_free & ~rd_pending;
	assign apb_rd = access & ~pwrite & mem_free & ~rd_pending;

	// a write is done at once, a read one cycle after the ram read.
	assign pready = apb_wr | rd_pending;
	assign prdata = rd_pending ? apb_data_t'(ram_dout) : '0;

	assign app_mem_rdata = ram_dout;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_pending <= 1'b0;
			app_mem_ack <= 1'b0;
		end else begin
			rd_pending <= apb_rd;
			app_mem_ack <= app_mem_rd;
		end
	end

	////////////////////////////////////////
	// memory port muxing
	////////////////////////////////////////

	assign ram_wr = init_wr | apb_wr;
	assign ram_waddr = init_wr ? init_addr : apb_index;
	assign ram_din = init_wr ? '0 : pwdata[width-1:0]; // bucket width only.
	assign ram_raddr = app_mem_rd ? app_mem_raddr : apb_index;

	ram_1r1w #(
		.width(width),
		.depth_nbits(depth_nbits)
	) u_ram (
		.clk(clk),
		.wr(ram_wr),
		.waddr(ram_waddr),
		.din(ram_din),
		.raddr(ram_raddr),
		.dout(ram_dout)
	);

	// lookup must not start before the clear sequence is over.
	app_rd_after_init: assert property (@(posedge clk) disable iff (reset)
		app_mem_rd |-> !init_wr);

endmodule

`default_nettype wire

//--- verilog/topic_mem.sv
`timescale 1ns/1ps
`default_nettype none

module topic_mem #(
	parameter int depth_nbits = 4,
	parameter int value_depth_nbits = 4
) (
	input wire clk,
	input wire reset,

	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire topic_pkg::apb_data_t paddr,
	input wire topic_pkg::apb_data_t pwdata,
	output logic pready,
	output topic_pkg::apb_data_t prdata,

	input wire verify_valid,
	input wire [value_depth_nbits-1:0] verify_tid,
	input wire topic_pkg::etime_t verify_etime,

	input wire ht0_rd,
	input wire [depth_nbits-1:0] ht0_raddr,
	output logic ht0_ack,
	output logic [value_depth_nbits:0] ht0_rdata,

	input wire ht1_rd,
	input wire [depth_nbits-1:0] ht1_raddr,
	output logic ht1_ack,
	output logic [value_depth_nbits:0] ht1_rdata,

	input wire key_rd,
	input wire [value_depth_nbits-1:0] key_raddr,
	output logic key_ack,
	output topic_pkg::key_t key_rdata,

	input wire etime_rd,
	input wire [value_depth_nbits-1:0] etime_raddr,
	output logic etime_ack,
	output topic_pkg::etime_t etime_rdata,

	output logic init_done
);

	import topic_pkg::*;

	localparam int bucket_nbits = value_depth_nbits + 1;
	localparam int init_nbits = (depth_nbits > value_depth_nbits) ? depth_nbits : value_depth_nbits;

	logic [init_nbits:0] init_cnt;
	logic init_wr;

	logic key_region;
	logic tbl1_sel;
	logic psel0;
	logic psel1;
	logic pready0;
	logic pready1;
	apb_data_t prdata0;
	apb_data_t prdata1;
	logic key_pready;

	logic key_wr_d1;
	logic [value_depth_nbits-1:0] key_waddr_d1;
	key_t key_wdata_d1;

	logic etime_wr_d1;
	logic [value_depth_nbits-1:0] etime_waddr_d1;
	etime_t etime_wdata_d1;

	////////////////////////////////////////
	// clear sequence after reset
	////////////////////////////////////////

	assign init_wr = ~init_cnt[init_nbits];
	assign init_done = init_cnt[init_nbits]; // high after the last clear write.

	always_ff @(posedge clk) begin
		if (reset) begin
			init_cnt <= '0;
		end else if (init_wr) begin
			init_cnt <= init_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// apb region decode
	////////////////////////////////////////

	assign key_region = apb_is_key_region(paddr, depth_nbits);
	assign tbl1_sel = apb_table_sel(paddr, depth_nbits);
	assign psel0 = psel & ~key_region & ~tbl1_sel;
	assign psel1 = psel & ~key_region & tbl1_sel;

	// key table is write-only, reads return zero.
	assign key_pready = psel & penable & key_region & init_done;

	always_comb begin
		if (key_region) begin
			pready = key_pready;
			prdata = '0;
		end else if (tbl1_sel) begin
			pready = pready1;
			prdata = prdata1;
		end else begin
			pready = pready0;
			prdata = prdata0;
		end
	end

	// delayed key and verify writes.
	always_ff @(posedge clk) begin
		if (reset) begin
			key_wr_d1 <= 1'b0;
			etime_wr_d1 <= 1'b0;
			key_ack <= 1'b0;
			etime_ack <= 1'b0;
		end else begin
			key_wr_d1 <= key_pready & pwrite;
			etime_wr_d1 <= verify_valid;
			key_ack <= key_rd;
			etime_ack <= etime_rd;
		end
	end

	always_ff @(posedge clk) begin
		key_waddr_d1 <= paddr[value_depth_nbits-1:0];
		key_wdata_d1 <= pwdata[$bits(key_t)-1:0];
		etime_waddr_d1 <= verify_tid;
		etime_wdata_d1 <= verify_etime;
	end

	pio_rw_wmem #(
		.width(bucket_nbits),
		.depth_nbits(depth_nbits)
	) u_ht0 (
		.clk(clk),
		.reset(reset),
		.psel(psel0),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pready(pready0),
		.prdata(prdata0),
		.app_mem_rd(ht0_rd),
		.app_mem_raddr(ht0_raddr),
		.app_mem_ack(ht0_ack),
		.app_mem_rdata(ht0_rdata),
		.init_wr(init_wr),
		.init_addr(init_cnt[depth_nbits-1:0])
	);

	pio_rw_wmem #(
		.width(bucket_nbits),
		.depth_nbits(depth_nbits)
	) u_ht1 (
		.clk(clk),
		.reset(reset),
		.psel(psel1),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pready(pready1),
		.prdata(prdata1),
		.app_mem_rd(ht1_rd),
		.app_mem_raddr(ht1_raddr),
		.app_mem_ack(ht1_ack),
		.app_mem_rdata(ht1_rdata),
		.init_wr(init_wr),
		.init_addr(init_cnt[depth_nbits-1:0])
	);

	ram_1r1w #(
		.width($bits(key_t)),
		.depth_nbits(value_depth_nbits)
	) u_key_ram (
		.clk(clk),
		.wr(init_wr | key_wr_d1),
		.waddr(init_wr ? init_cnt[value_depth_nbits-1:0] : key_waddr_d1),
		.din(init_wr ? key_t'(0) : key_wdata_d1),
		.raddr(key_raddr),
		.dout(key_rdata)
	);

	ram_1r1w #(
		.width($bits(etime_t)),
		.depth_nbits(value_depth_nbits)
	) u_etime_ram (
		.clk(clk),
		.wr(init_wr | etime_wr_d1),
		.waddr(init_wr ? init_cnt[value_depth_nbits-1:0] : etime_waddr_d1),
		.din(init_wr ? etime_t'(0) : etime_wdata_d1),
		.raddr(etime_raddr),
		.dout(etime_rdata)
	);

	pready_in_access: assert property (@(posedge clk) disable iff (reset)
		pready |-> (psel && penable));

endmodule

`default_nettype wire

//--- verilog/topic_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module topic_lookup #(
	parameter int depth_nbits = 4,
	parameter int value_depth_nbits = 4
) (
	input wire clk,
	input wire reset,
	input wire init_done,

	input wire query_valid,
	input wire topic_pkg::key_t query_key,
	output logic query_ready,

	output logic ht0_rd,
	output logic [depth_nbits-1:0] ht0_raddr,
	input wire ht0_ack,
	input wire [value_depth_nbits:0] ht0_rdata,

	output logic ht1_rd,
	output logic [depth_nbits-1:0] ht1_raddr,
	input wire ht1_ack,
	input wire [value_depth_nbits:0] ht1_rdata,

	output logic key_rd,
	output logic [value_depth_nbits-1:0] key_raddr,
	input wire key_ack,
	input wire topic_pkg::key_t key_rdata,

	output logic etime_rd,
	output logic [value_depth_nbits-1:0] etime_raddr,
	input wire etime_ack,
	input wire topic_pkg::etime_t etime_rdata,

	output logic result_valid,
	output logic result_hit,
	output logic [value_depth_nbits-1:0] result_tid,
	output topic_pkg::etime_t result_etime
);

	import topic_pkg::*;

	localparam int bucket_nbits = value_depth_nbits + 1;

	lookup_state_t state;
	lookup_state_t next_state;

	logic accept;
	key_t hash0_full;
	key_t hash1_full;
	key_t key_q;
	logic [bucket_nbits-1:0] b0_q;
	logic [bucket_nbits-1:0] b1_q;
	logic [value_depth_nbits-1:0] hit_tid;
	logic done_hit;
	logic done_miss;

	assign query_ready = init_done & (state == IDLE);
	assign accept = query_valid & query_ready;

	// both buckets are read on the accept cycle.
	assign hash0_full = topic_hash0(query_key, depth_nbits);
	assign hash1_full = topic_hash1(query_key, depth_nbits);
	assign ht0_rd = accept;
	assign ht1_rd = accept;
	assign ht0_raddr = hash0_full[depth_nbits-1:0];
	assign ht1_raddr = hash1_full[depth_nbits-1:0];

	always_comb begin
		next_state = state;
		key_rd = 1'b0;
		key_raddr = b1_q[value_depth_nbits-1:0];
		etime_rd = 1'b0;
		etime_raddr = b1_q[value_depth_nbits-1:0];
		done_hit = 1'b0;
		done_miss = 1'b0;
		case (state)
			IDLE: begin
				if (accept) begin
					next_state = PROBE;
				end
			end
			PROBE: begin
				key_rd = ht0_ack & ht0_rdata[value_depth_nbits]; // table 0 first.
				key_raddr = ht0_rdata[value_depth_nbits-1:0];
				next_state = KEY0;
			end
			KEY0: begin
				etime_raddr = b0_q[value_depth_nbits-1:0];
				if (b0_q[value_depth_nbits] && key_ack && key_rdata == key_q) begin
					etime_rd = 1'b1;
					next_state = EXPIRY;
				end else if (b1_q[value_depth_nbits]) begin
					key_rd = 1'b1;
					next_state = KEY1;
				end else begin
					done_miss = 1'b1;
					next_state = IDLE;
				end
			end
			KEY1: begin
				if (key_ack && key_rdata == key_q) begin
					etime_rd = 1'b1;
					next_state = EXPIRY;
				end else begin
					done_miss = 1'b1; // wrong key in the only other bucket.
					next_state = IDLE;
				end
			end
			EXPIRY: begin
				if (etime_ack) begin
					done_hit = 1'b1;
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			result_valid <= 1'b0;
		end else begin
			state <= next_state;
			result_valid <= done_hit | done_miss;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			key_q <= query_key;
		end
		if (ht0_ack) begin
			b0_q <= ht0_rdata;
		end
		if (ht1_ack) begin
			b1_q <= ht1_rdata;
		end
		if (etime_rd) begin
			hit_tid <= etime_raddr;
		end
		if (done_hit | done_miss) begin
			result_hit <= done_hit;
			result_tid <= done_hit ? hit_tid : '0;
			result_etime <= done_hit ? etime_rdata : '0; // miss reports zero.
		end
	end

	result_single_cycle: assert property (@(posedge clk) disable iff (reset)
		result_valid |=> !result_valid);

endmodule

`default_nettype wire

//--- verilog/topic_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module topic_classifier #(
	parameter int depth_nbits = 4,
	parameter int value_depth_nbits = 4
) (
	input wire clk,
	input wire reset,

	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire topic_pkg::apb_data_t paddr,
	input wire topic_pkg::apb_data_t pwdata,
	output logic pready,
	output topic_pkg::apb_data_t prdata,

	input wire verify_valid,
	input wire [value_depth_nbits-1:0] verify_tid,
	input wire topic_pkg::etime_t verify_etime,

	input wire query_valid,
	input wire topic_pkg::key_t query_key,
	output logic query_ready,

	output logic result_valid,
	output logic result_hit,
	output logic [value_depth_nbits-1:0] result_tid,
	output topic_pkg::etime_t result_etime
);

	import topic_pkg::*;

	logic init_done;
	logic ht0_rd, ht1_rd, key_rd, etime_rd;
	logic ht0_ack, ht1_ack, key_ack, etime_ack;
	logic [depth_nbits-1:0] ht0_raddr, ht1_raddr;
	logic [value_depth_nbits:0] ht0_rdata, ht1_rdata; // valid bit over tid.
	logic [value_depth_nbits-1:0] key_raddr, etime_raddr;
	key_t key_rdata;
	etime_t etime_rdata;

	topic_mem #(
		.depth_nbits(depth_nbits),
		.value_depth_nbits(value_depth_nbits)
	) u_mem (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .pready(pready), .prdata(prdata),
		.verify_valid(verify_valid), .verify_tid(verify_tid), .verify_etime(verify_etime),
		.ht0_rd(ht0_rd), .ht0_raddr(ht0_raddr), .ht0_ack(ht0_ack), .ht0_rdata(ht0_rdata),
		.ht1_rd(ht1_rd), .ht1_raddr(ht1_raddr), .ht1_ack(ht1_ack), .ht1_rdata(ht1_rdata),
		.key_rd(key_rd), .key_raddr(key_raddr), .key_ack(key_ack), .key_rdata(key_rdata),
		.etime_rd(etime_rd), .etime_raddr(etime_raddr), .etime_ack(etime_ack),
		.etime_rdata(etime_rdata),
		.init_done(init_done)
	);

	topic_lookup #(
		.depth_nbits(depth_nbits),
		.value_depth_nbits(value_depth_nbits)
	) u_lookup (
		.clk(clk), .reset(reset), .init_done(init_done),
		.query_valid(query_valid), .query_key(query_key), .query_ready(query_ready),
		.ht0_rd(ht0_rd), .ht0_raddr(ht0_raddr), .ht0_ack(ht0_ack), .ht0_rdata(ht0_rdata),
		.ht1_rd(ht1_rd), .ht1_raddr(ht1_raddr), .ht1_ack(ht1_ack), .ht1_rdata(ht1_rdata),
		.key_rd(key_rd), .key_raddr(key_raddr), .key_ack(key_ack), .key_rdata(key_rdata),
		.etime_rd(etime_rd), .etime_raddr(etime_raddr), .etime_ack(etime_ack),
		.etime_rdata(etime_rdata),
		.result_valid(result_valid), .result_hit(result_hit),
		.result_tid(result_tid), .result_etime(result_etime)
	);

endmodule

`default_nettype wire

//--- verification/tb_topic_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module tb_topic_classifier;

	import topic_pkg::*;

	localparam int depth_nbits = 4;
	localparam int value_depth_nbits = 4;
	localparam int bucket_nbits = value_depth_nbits + 1;
	localparam int row_cycles = 40;
	localparam int clear_cycles = 64;

	typedef enum logic [1:0] {
		OP_APB_WRITE,
		OP_APB_READ,
		OP_VERIFY,
		OP_LOOKUP
	} op_t;

	typedef struct packed {
		op_t op;
		apb_data_t addr;                  // apb address, verify tid or lookup key.
		apb_data_t data;                  // write word, expected read word or etime.
		logic hit;
		logic [value_depth_nbits-1:0] tid;
		etime_t etime;
	} row_t;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	apb_data_t paddr;
	apb_data_t pwdata;
	logic pready;
	apb_data_t prdata;
	logic verify_valid;
	logic [value_depth_nbits-1:0] verify_tid;
	etime_t verify_etime;
	logic query_valid;
	key_t query_key;
	logic query_ready;
	logic result_valid;
	logic result_hit;
	logic [value_depth_nbits-1:0] result_tid;
	etime_t result_etime;

	row_t rows[$];
	string row_names[$];

	// table contents as software and the verify stream leave them.
	logic [bucket_nbits-1:0] ht0_model [0:(1<<depth_nbits)-1];
	logic [bucket_nbits-1:0] ht1_model [0:(1<<depth_nbits)-1];
	key_t key_model [0:(1<<value_depth_nbits)-1];
	etime_t etime_model [0:(1<<value_depth_nbits)-1];

	int cycle_count = 0;
	int cycle_limit = 0;
	logic [31:0] rng_state;

	topic_classifier #(
		.depth_nbits(depth_nbits),
		.value_depth_nbits(value_depth_nbits)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pready(pready),
		.prdata(prdata),
		.verify_valid(verify_valid),
		.verify_tid(verify_tid),
		.verify_etime(verify_etime),
		.query_valid(query_valid),
		.query_key(query_key),
		.query_ready(query_ready),
		.result_valid(result_valid),
		.result_hit(result_hit),
		.result_tid(result_tid),
		.result_etime(result_etime)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			fail_run($sformatf("timeout, the run did not finish within %0d cycles", cycle_limit));
		end
	end

	////////////////////////////////////////
	// failure and compare tasks
	////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_apb(input string name, input apb_data_t exp, input apb_data_t act);
		if (exp !== act) begin
			fail_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_lookup(input string name,
			input logic exp_hit, input logic [value_depth_nbits-1:0] exp_tid,
			input etime_t exp_etime, input logic act_hit,
			input logic [value_depth_nbits-1:0] act_tid, input etime_t act_etime);
		if (exp_hit !== act_hit || exp_tid !== act_tid || exp_etime !== act_etime) begin
			fail_run($sformatf("ERR %s: expected hit %b tid %0d etime %h, actual hit %b tid %0d etime %h",
				name, exp_hit, exp_tid, exp_etime, act_hit, act_tid, act_etime));
		end
	endtask

	////////////////////////////////////////
	// drivers
	////////////////////////////////////////

	task automatic apb_transfer(input logic is_write, input apb_data_t addr,
			input apb_data_t wdata, output apb_data_t rdata);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = is_write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		while (pready !== 1'b1) begin // access phase holds until ready.
			@(negedge clk);
			#1;
		end
		rdata = prdata;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic send_verify(input logic [value_depth_nbits-1:0] tid, input etime_t etime);
		@(negedge clk);
		verify_valid = 1'b1;
		verify_tid = tid;
		verify_etime = etime;
		@(negedge clk);
		verify_valid = 1'b0;
	endtask

	task automatic run_lookup(input key_t key, output logic hit,
			output logic [value_depth_nbits-1:0] tid, output etime_t etime);
		@(negedge clk);
		query_valid = 1'b1;
		query_key = key;
		while (query_ready !== 1'b1) begin
			@(negedge clk);
		end
		@(negedge clk); // taken on the edge before.
		query_valid = 1'b0;
		while (result_valid !== 1'b1) begin
			@(negedge clk);
		end
		hit = result_hit;
		tid = result_tid;
		etime = result_etime;
	endtask

	////////////////////////////////////////
	// stimulus table and table model
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic apb_data_t bucket_addr(input logic tbl, input logic [depth_nbits-1:0] idx);
		apb_data_t a;
		a = '0;
		a[depth_nbits] = tbl;
		a[depth_nbits-1:0] = idx;
		return a;
	endfunction

	function automatic apb_data_t key_addr(input logic [value_depth_nbits-1:0] tid);
		apb_data_t a;
		a = '0;
		a[depth_nbits+1] = 1'b1; // key region.
		a[value_depth_nbits-1:0] = tid;
		return a;
	endfunction

	function automatic apb_data_t bucket_word(input logic [value_depth_nbits-1:0] tid);
		apb_data_t w;
		w = '0;
		w[value_depth_nbits] = 1'b1;
		w[value_depth_nbits-1:0] = tid;
		return w;
	endfunction

	task automatic predict_lookup(input key_t key, output logic hit,
			output logic [value_depth_nbits-1:0] tid, output etime_t etime);
		key_t h0;
		key_t h1;
		logic [bucket_nbits-1:0] b0;
		logic [bucket_nbits-1:0] b1;
		h0 = topic_hash0(key, depth_nbits);
		h1 = topic_hash1(key, depth_nbits);
		b0 = ht0_model[h0[depth_nbits-1:0]];
		b1 = ht1_model[h1[depth_nbits-1:0]];
		hit = 1'b0;
		tid = '0;
		etime = '0;
		// table 0 first, table 1 only when table 0 does not confirm.
		if (b0[value_depth_nbits] && key_model[b0[value_depth_nbits-1:0]] == key) begin
			hit = 1'b1;
			tid = b0[value_depth_nbits-1:0];
		end else if (b1[value_depth_nbits] && key_model[b1[value_depth_nbits-1:0]] == key) begin
			hit = 1'b1;
			tid = b1[value_depth_nbits-1:0];
		end
		if (hit) begin
			etime = etime_model[tid];
		end
	endtask

	task automatic write_row(input string name, input apb_data_t addr, input apb_data_t data);
		row_t r;
		r = '0;
		r.op = OP_APB_WRITE;
		r.addr = addr;
		r.data = data;
		rows.push_back(r);
		row_names.push_back(name);
		if (addr[depth_nbits+1]) begin
			key_model[addr[value_depth_nbits-1:0]] = data[15:0];
		end else if (addr[depth_nbits]) begin
			ht1_model[addr[depth_nbits-1:0]] = data[bucket_nbits-1:0]; // bucket width only.
		end else begin
			ht0_model[addr[depth_nbits-1:0]] = data[bucket_nbits-1:0];
		end
	endtask

	task automatic read_row(input string name, input apb_data_t addr);
		row_t r;
		r = '0;
		r.op = OP_APB_READ;
		r.addr = addr;
		if (addr[depth_nbits+1]) begin
			r.data = '0; // key table is write-only.
		end else if (addr[depth_nbits]) begin
			r.data = apb_data_t'(ht1_model[addr[depth_nbits-1:0]]);
		end else begin
			r.data = apb_data_t'(ht0_model[addr[depth_nbits-1:0]]);
		end
		rows.push_back(r);
		row_names.push_back(name);
	endtask

	task automatic verify_row(input string name, input logic [value_depth_nbits-1:0] tid,
			input etime_t etime);
		row_t r;
		r = '0;
		r.op = OP_VERIFY;
		r.addr = apb_data_t'(tid);
		r.data = apb_data_t'(etime);
		rows.push_back(r);
		row_names.push_back(name);
		etime_model[tid] = etime;
	endtask

	task automatic lookup_row(input string name, input key_t key);
		row_t r;
		logic hit;
		logic [value_depth_nbits-1:0] tid;
		etime_t etime;
		predict_lookup(key, hit, tid, etime);
		r = '0;
		r.op = OP_LOOKUP;
		r.addr = apb_data_t'(key);
		r.hit = hit;
		r.tid = tid;
		r.etime = etime;
		rows.push_back(r);
		row_names.push_back(name);
	endtask

	task automatic build_table();
		key_t key_a;
		key_t key_b;
		key_t key_c;
		key_t key_r;
		key_t h0;
		key_t h1;
		logic found;
		int tries;
		for (int i = 0; i < (1 << depth_nbits); i++) begin
			ht0_model[i] = '0;
			ht1_model[i] = '0;
		end
		for (int i = 0; i < (1 << value_depth_nbits); i++) begin
			key_model[i] = '0;
			etime_model[i] = '0;
		end
		// everything is cleared after init.
		lookup_row("init_miss_1234", 16'h1234);
		lookup_row("init_miss_beef", 16'hbeef);
		read_row("init_t0_0", bucket_addr(1'b0, 4'd0));
		read_row("init_t0_9", bucket_addr(1'b0, 4'd9));
		read_row("init_t1_15", bucket_addr(1'b1, 4'd15));
		read_row("init_key_5", key_addr(4'd5));
		write_row("wr_t0_3", bucket_addr(1'b0, 4'd3), 32'hffff_fff7);
		read_row("rd_t0_3", bucket_addr(1'b0, 4'd3));
		write_row("wr_t1_12", bucket_addr(1'b1, 4'd12), 32'h0000_0025);
		read_row("rd_t1_12", bucket_addr(1'b1, 4'd12));
		// key a lives in table 0 at tid 2.
		key_a = 16'ha5c3;
		h0 = topic_hash0(key_a, depth_nbits);
		write_row("key_a_tid2", key_addr(4'd2), apb_data_t'(key_a));
		write_row("bucket_a_t0", bucket_addr(1'b0, h0[depth_nbits-1:0]), bucket_word(4'd2));
		lookup_row("hit_a_t0", key_a);
		verify_row("verify_tid2", 4'd2, 16'h7e11);
		lookup_row("hit_a_etime", key_a);
		// key b only in table 1.
		key_b = 16'h3c5a;
		h1 = topic_hash1(key_b, depth_nbits);
		write_row("key_b_tid9", key_addr(4'd9), apb_data_t'(key_b));
		write_row("bucket_b_t1", bucket_addr(1'b1, h1[depth_nbits-1:0]), bucket_word(4'd9));
		verify_row("verify_tid9", 4'd9, 16'h0042);
		lookup_row("hit_b_t1", key_b);
		read_row("rd_bucket_b", bucket_addr(1'b1, h1[depth_nbits-1:0]));
		// valid bucket that points at someone else's key.
		key_c = 16'h0001;
		h0 = topic_hash0(key_c, depth_nbits);
		write_row("key_other_tid11", key_addr(4'd11), 32'h0000_1111);
		write_row("bucket_c_t0", bucket_addr(1'b0, h0[depth_nbits-1:0]), bucket_word(4'd11));
		lookup_row("miss_c_wrong_key", key_c);
		rng_state = 32'd31519;
		for (int n = 0; n < 8; n++) begin
			found = 1'b0;
			tries = 0;
			key_r = '0;
			while (!found && tries < 64) begin
				rng_state = xorshift32(rng_state);
				key_r = rng_state[15:0];
				h0 = topic_hash0(key_r, depth_nbits);
				h1 = topic_hash1(key_r, depth_nbits);
				tries++;
				if (key_r != '0 && !ht0_model[h0[depth_nbits-1:0]][value_depth_nbits]
						&& !ht1_model[h1[depth_nbits-1:0]][value_depth_nbits]) begin
					found = 1'b1;
				end
			end
			lookup_row($sformatf("rand_miss_%0d_%h", n, key_r), key_r);
			read_row($sformatf("rand_read_%0d", n),
				bucket_addr(rng_state[20], rng_state[16 +: depth_nbits]));
		end
	endtask

	task automatic apply_row(input row_t r, input string name);
		apb_data_t rdata;
		logic hit;
		logic [value_depth_nbits-1:0] tid;
		etime_t etime;
		case (r.op)
			OP_APB_WRITE: begin
				apb_transfer(1'b1, r.addr, r.data, rdata);
			end
			OP_APB_READ: begin
				apb_transfer(1'b0, r.addr, '0, rdata);
				check_apb(name, r.data, rdata);
			end
			OP_VERIFY: begin
				send_verify(r.addr[value_depth_nbits-1:0], r.data[15:0]);
			end
			default: begin
				run_lookup(r.addr[15:0], hit, tid, etime);
				check_lookup(name, r.hit, r.tid, r.etime, hit, tid, etime);
			end
		endcase
	endtask

	initial begin
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		verify_valid = 1'b0;
		verify_tid = '0;
		verify_etime = '0;
		query_valid = 1'b0;
		query_key = '0;
		build_table();
		cycle_limit = rows.size() * row_cycles + clear_cycles;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		while (query_ready !== 1'b1) begin // clear sequence still running.
			@(negedge clk);
		end
		for (int i = 0; i < rows.size(); i++) begin
			apply_row(rows[i], row_names[i]);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
verilog/topic_pkg.sv
verilog/ram_1r1w.sv
verilog/pio_rw_wmem.sv
verilog/topic_mem.sv
verilog/topic_lookup.sv
verilog/topic_classifier.sv
verification/tb_topic_classifier.sv

//--- run_sim.sh
#!/bin/sh
# compile with verilator, run the testbench and look for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_topic_classifier -f sim.f \
	&& ./obj_dir/Vtb_topic_classifier 2>&1 | tee /dev/stderr | grep -qF '*** PASSED ***' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
